// ==== hdl/nibble_core_pkg.sv ====
package nibble_core_pkg;

    // Data moves one nibble per clock, least significant first
    localparam int NUM_NIBBLES = 8;

    // Supported CSRs
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_INSTRET  = 12'hC02;

    typedef logic [3:0]  nibble_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  nibble_idx_t;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_LUI,
        OP_CSRRW
    } op_t;

    // Source of the nibble written to rd
    typedef enum logic [1:0] {
        WB_ALU,
        WB_SLT,     // Compare bit in nibble 0
        WB_IMM,
        WB_CSR
    } wb_sel_t;

    typedef enum logic {
        SEQ_EXEC,   // First pass
        SEQ_WRITE   // Second pass of SLT
    } seq_state_t;

endpackage

// ==== hdl/nibble_sequencer.sv ====
`timescale 1ns/1ns

module nibble_sequencer (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      instr_valid,
    input  nibble_core_pkg::op_t      op,
    output logic                      instr_ready,
    output nibble_core_pkg::nibble_idx_t nibble_idx,
    output nibble_core_pkg::seq_state_t  state,
    output logic                      wr_en,
    output logic                      alu_start,
    output logic                      csr_en,
    output logic                      retire,
    output nibble_core_pkg::wb_sel_t  wb_sel
);
    import nibble_core_pkg::*;

    logic last_nibble;
    logic two_pass;
    logic writes_rd;

    assign last_nibble = (nibble_idx == nibble_idx_t'(NUM_NIBBLES - 1));
    assign two_pass    = (op == OP_SLT);
    assign writes_rd   = (op != OP_NOP);

    // Counter only moves while an instruction is offered
    always_ff @(posedge clk) begin
        if (!rstn) begin
            nibble_idx <= '0;
            state      <= SEQ_EXEC;
        end else if (instr_valid) begin
            nibble_idx <= nibble_idx + 3'd1;
            if (last_nibble) begin
                if (state == SEQ_EXEC && two_pass)
                    state <= SEQ_WRITE;
                else
                    state <= SEQ_EXEC;
            end
        end
    end

    // Writeback source from the operation
    always_comb begin
        case (op)
            OP_SLT:   wb_sel = WB_SLT;
            OP_LUI:   wb_sel = WB_IMM;
            OP_CSRRW: wb_sel = WB_CSR;
            default:  wb_sel = WB_ALU;   // ALU ops, NOP ignored via wr_en
        endcase
    end

    // SLT writes in its second pass only
    always_comb begin
        wr_en = 1'b0;
        if (instr_valid && writes_rd) begin
            if (two_pass)
                wr_en = (state == SEQ_WRITE);
            else
                wr_en = (state == SEQ_EXEC);
        end
    end

    assign instr_ready = instr_valid && last_nibble &&
                         (!two_pass || state == SEQ_WRITE);
    assign alu_start   = (state == SEQ_EXEC) && (nibble_idx == '0);
    assign csr_en      = instr_valid && (state == SEQ_EXEC) && (op == OP_CSRRW);
    assign retire      = instr_ready && writes_rd;   // Handshake of a real instruction

endmodule

// ==== hdl/nibble_alu.sv ====
`timescale 1ns/1ns

module nibble_alu (
    input  logic                         clk,
    input  nibble_core_pkg::op_t         op,
    input  logic                         alu_start,
    input  nibble_core_pkg::nibble_idx_t nibble_idx,
    input  nibble_core_pkg::nibble_t     a,
    input  nibble_core_pkg::nibble_t     b,
    output nibble_core_pkg::nibble_t     alu_nibble,
    output logic                         slt_bit
);
    import nibble_core_pkg::*;

    logic       subtract;
    logic       cy;
    logic       cy_in;
    logic       cmp_pass;   // Set during the compare pass of SLT
    nibble_t    b_in;
    logic [4:0] sum;
    logic       lt;

    assign subtract = (op == OP_SUB) || (op == OP_SLT);
    assign b_in     = subtract ? ~b : b;
    assign cy_in    = alu_start ? subtract : cy;   // +1 for two's complement
    assign sum      = {1'b0, a} + {1'b0, b_in} + {4'b0000, cy_in};

    always_comb begin
        case (op)
            OP_AND:  alu_nibble = a & b;
            OP_OR:   alu_nibble = a | b;
            OP_XOR:  alu_nibble = a ^ b;
            default: alu_nibble = sum[3:0];
        endcase
    end

    // Signs differ: a is less if negative. Otherwise no carry means a < b
    assign lt = (a[3] != b[3]) ? a[3] : ~sum[4];

    always_ff @(posedge clk) begin
        cy <= sum[4];
        if (alu_start)
            cmp_pass <= 1'b1;
        else if (nibble_idx == nibble_idx_t'(NUM_NIBBLES - 1))
            cmp_pass <= 1'b0;
        if (cmp_pass && nibble_idx == nibble_idx_t'(NUM_NIBBLES - 1))
            slt_bit <= lt;   // Top nibble of the first pass
    end

endmodule

// ==== hdl/nibble_regfile.sv ====
`timescale 1ns/1ns

module nibble_regfile (
    input  logic                         clk,
    input  nibble_core_pkg::nibble_idx_t nibble_idx,
    input  nibble_core_pkg::reg_addr_t   rs1,
    input  nibble_core_pkg::reg_addr_t   rs2,
    input  nibble_core_pkg::reg_addr_t   rd,
    input  logic                         wr_en,
    input  nibble_core_pkg::wb_sel_t     wb_sel,
    input  nibble_core_pkg::word_t       imm,
    input  nibble_core_pkg::nibble_t     alu_nibble,
    input  nibble_core_pkg::nibble_t     csr_nibble,
    input  logic                         slt_bit,
    output nibble_core_pkg::nibble_t     rs1_nibble,
    output nibble_core_pkg::nibble_t     rs2_nibble,
    output logic                         wb_valid,
    output nibble_core_pkg::reg_addr_t   wb_rd,
    output nibble_core_pkg::nibble_idx_t wb_index,
    output nibble_core_pkg::nibble_t     wb_data
);
    import nibble_core_pkg::*;

    word_t      regs [1:15];   // x0 has no storage
    logic [4:0] bit_pos;
    nibble_t    wr_nibble;
    logic       do_write;

    assign bit_pos = {nibble_idx, 2'b00};

    assign rs1_nibble = (rs1 == '0) ? '0 : regs[rs1][bit_pos +: 4];
    assign rs2_nibble = (rs2 == '0) ? '0 : regs[rs2][bit_pos +: 4];

    always_comb begin
        case (wb_sel)
            WB_SLT:  wr_nibble = (nibble_idx == '0) ? {3'b000, slt_bit} : 4'h0;
            WB_IMM:  wr_nibble = imm[bit_pos +: 4];
            WB_CSR:  wr_nibble = csr_nibble;
            default: wr_nibble = alu_nibble;
        endcase
    end

    assign do_write = wr_en && (rd != '0);

    always_ff @(posedge clk) begin
        if (do_write)
            regs[rd][bit_pos +: 4] <= wr_nibble;
    end

    // Report mirrors the register write
    assign wb_valid = do_write;
    assign wb_rd    = rd;
    assign wb_index = nibble_idx;
    assign wb_data  = wr_nibble;

endmodule

// ==== hdl/nibble_csr.sv ====
`timescale 1ns/1ns

module nibble_csr (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         csr_en,
    input  logic                         retire,
    input  nibble_core_pkg::nibble_idx_t nibble_idx,
    input  nibble_core_pkg::csr_addr_t   csr_addr,
    input  nibble_core_pkg::nibble_t     wdata,
    output nibble_core_pkg::nibble_t     csr_nibble
);
    import nibble_core_pkg::*;

    word_t   mscratch;   // Rotates, nibble 0 always at the bottom
    word_t   instret;
    logic    sel_mscratch;
    nibble_t scratch_in;

    assign sel_mscratch = (csr_addr == CSR_MSCRATCH);

    // Old nibble goes back in unless this CSR is the target
    assign scratch_in = sel_mscratch ? wdata : mscratch[3:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mscratch <= '0;
        end else if (csr_en) begin
            mscratch <= {scratch_in, mscratch[31:4]};
        end
    end

    // Read only, counts retired instructions
    always_ff @(posedge clk) begin
        if (!rstn)
            instret <= '0;
        else if (retire)
            instret <= instret + 32'd1;
    end

    always_comb begin
        case (csr_addr)
            CSR_MSCRATCH: csr_nibble = mscratch[3:0];
            CSR_INSTRET:  csr_nibble = instret[{nibble_idx, 2'b00} +: 4];
            default:      csr_nibble = 4'h0;   // Unknown CSRs read zero
        endcase
    end

endmodule

// ==== hdl/nibble_core.sv ====
`timescale 1ns/1ns

module nibble_core (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         instr_valid,
    output logic                         instr_ready,
    input  nibble_core_pkg::op_t         op,
    input  nibble_core_pkg::reg_addr_t   rd,
    input  nibble_core_pkg::reg_addr_t   rs1,
    input  nibble_core_pkg::reg_addr_t   rs2,
    input  nibble_core_pkg::word_t       imm,
    input  nibble_core_pkg::csr_addr_t   csr_addr,
    output logic                         wb_valid,
    output nibble_core_pkg::reg_addr_t   wb_rd,
    output nibble_core_pkg::nibble_idx_t wb_index,
    output nibble_core_pkg::nibble_t     wb_data
);
    import nibble_core_pkg::*;

    nibble_idx_t nibble_idx;
    wb_sel_t     wb_sel;
    logic        wr_en;
    logic        alu_start;
    logic        csr_en;
    logic        retire;
    nibble_t     rs1_nibble;
    nibble_t     rs2_nibble;
    nibble_t     alu_nibble;
    nibble_t     csr_nibble;
    logic        slt_bit;

    nibble_sequencer u_seq (
        .clk(clk), .rstn(rstn),
        .instr_valid(instr_valid), .op(op), .instr_ready(instr_ready),
        .nibble_idx(nibble_idx), .state(), .wr_en(wr_en),
        .alu_start(alu_start), .csr_en(csr_en), .retire(retire), .wb_sel(wb_sel)
    );

    nibble_alu u_alu (
        .clk(clk), .op(op), .alu_start(alu_start), .nibble_idx(nibble_idx),
        .a(rs1_nibble), .b(rs2_nibble),
        .alu_nibble(alu_nibble), .slt_bit(slt_bit)
    );

    nibble_regfile u_regs (
        .clk(clk), .nibble_idx(nibble_idx),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .wr_en(wr_en), .wb_sel(wb_sel), .imm(imm),
        .alu_nibble(alu_nibble), .csr_nibble(csr_nibble), .slt_bit(slt_bit),
        .rs1_nibble(rs1_nibble), .rs2_nibble(rs2_nibble),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_index(wb_index), .wb_data(wb_data)
    );

    // CSRRW takes its write data from rs1
    nibble_csr u_csr (
        .clk(clk), .rstn(rstn),
        .csr_en(csr_en), .retire(retire), .nibble_idx(nibble_idx),
        .csr_addr(csr_addr), .wdata(rs1_nibble), .csr_nibble(csr_nibble)
    );

endmodule

// ==== bench/nibble_core_properties.sv ====
`timescale 1ns/1ns

module nibble_core_properties (
    input logic                       clk,
    input logic                       rstn,
    input logic                       instr_valid,
    input logic                       instr_ready,
    input logic                       wb_valid,
    input nibble_core_pkg::reg_addr_t wb_rd
);

    int assertion_failures = 0;

    // Ready only on an offered instruction
    ready_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
        instr_ready |-> instr_valid)
        else begin
            assertion_failures++;
            $error("instr_ready high without instr_valid");
        end

    no_x0_report: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid |-> (wb_rd != '0))
        else begin
            assertion_failures++;
            $error("wb_valid reported a write to x0");
        end

    quiet_after_reset: assert property (@(posedge clk)
        !rstn |=> (!instr_ready && !wb_valid))
        else begin
            assertion_failures++;
            $error("instr_ready or wb_valid high in the cycle after reset");
        end

endmodule

bind nibble_core nibble_core_properties u_props (.*);

// ==== bench/nibble_core_tb.sv ====
`timescale 1ns/1ns

module nibble_core_tb;
    import nibble_core_pkg::*;

    // About 100 instructions of 9 or 17 clocks plus idle gaps and margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        rstn;
    logic        instr_valid;
    logic        instr_ready;
    op_t         op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       imm;
    csr_addr_t   csr_addr;
    logic        wb_valid;
    reg_addr_t   wb_rd;
    nibble_idx_t wb_index;
    nibble_t     wb_data;

    word_t ref_regs [16];   // Reference register file with x0 held at zero
    word_t ref_mscratch;
    word_t ref_instret;
    int    seed;
    int    errors;
    int    cycle_count = 0;

    nibble_core UUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            errors++;
            $display("error %s expected %0h got %0h", name, exp, act);
        end
    endtask

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(1 + {$random(seed)} % 15);   // Never x0
    endfunction

    // Result that rd should receive under the instruction set rules
    function automatic word_t expected_result(input op_t o, input word_t a, input word_t b,
                                              input word_t im, input csr_addr_t ca);
        case (o)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_LUI:   return im;
            OP_CSRRW: begin
                if (ca == CSR_MSCRATCH)
                    return ref_mscratch;
                if (ca == CSR_INSTRET)
                    return ref_instret;
                return '0;
            end
            default:  return '0;
        endcase
    endfunction

    task automatic idle_for(input int n);
        repeat (n) begin
            @(negedge clk);
            if (wb_valid !== 1'b0 || instr_ready !== 1'b0) begin
                errors++;
                $display("Writeback or ready active while no instruction was offered");
            end
        end
    endtask

    // One instruction from offer to handshake with its writeback gathered into a word
    task automatic issue(input op_t o, input reg_addr_t d, input reg_addr_t s1,
                         input reg_addr_t s2, input word_t im, input csr_addr_t ca);
        word_t exp;
        word_t got;
        word_t a;
        int    clocks;
        int    seen;
        int    first_wb;
        a = ref_regs[s1];
        exp = expected_result(o, a, ref_regs[s2], im, ca);
        got = '0;
        clocks = 0;
        seen = 0;
        first_wb = 0;
        @(posedge clk);
        instr_valid <= 1'b1;
        op <= o;
        rd <= d;
        rs1 <= s1;
        rs2 <= s2;
        imm <= im;
        csr_addr <= ca;
        do begin
            @(negedge clk);
            clocks++;
            if (wb_valid) begin
                if (seen == 0)
                    first_wb = clocks;
                check_reg("wb_rd", d, wb_rd);
                check_count("wb_index", seen, int'(wb_index));   // Nibbles in index order
                got[{wb_index, 2'b00} +: 4] = wb_data;
                seen++;
            end
        end while (instr_ready !== 1'b1);
        @(posedge clk);   // Handshake edge
        instr_valid <= 1'b0;
        check_count("latency", (o == OP_SLT) ? 16 : 8, clocks);
        if (o == OP_NOP || d == '0) begin
            check_count("wb nibbles", 0, seen);
        end else begin
            check_count("wb nibbles", 8, seen);
            check_count("first wb clock", (o == OP_SLT) ? 9 : 1, first_wb);
            check_word("rd value", exp, got);
            ref_regs[d] = exp;
        end
        if (o == OP_CSRRW && ca == CSR_MSCRATCH)
            ref_mscratch = a;
        if (o != OP_NOP)
            ref_instret++;
    endtask

    task automatic load_registers();
        int r;
        for (r = 1; r < 16; r++)
            issue(OP_LUI, reg_addr_t'(r), 4'd0, 4'd0, $random(seed), '0);
    endtask

    task automatic alu_ops();
        op_t ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        foreach (ops[i])
            repeat (4) issue(ops[i], rand_reg(), rand_reg(), rand_reg(), '0, '0);
    endtask

    task automatic signed_compare();
        word_t lhs [8] = '{32'h5, 32'h8000_0000, 32'h0, 32'hFFFF_FFFF, 32'h1,
                           32'h7FFF_FFFF, 32'h8000_0000, 32'h8000_0000};
        word_t rhs [8] = '{32'h5, 32'h0, 32'h8000_0000, 32'h1, 32'hFFFF_FFFF,
                           32'h8000_0000, 32'h8000_0000, 32'h8000_0001};
        int    i;
        for (i = 0; i < 12; i++) begin
            // Edge pairs first, then random operands
            issue(OP_LUI, 4'd10, 4'd0, 4'd0, (i < 8) ? lhs[i] : $random(seed), '0);
            issue(OP_LUI, 4'd11, 4'd0, 4'd0, (i < 8) ? rhs[i] : $random(seed), '0);
            issue(OP_SLT, 4'd12, 4'd10, 4'd11, '0, '0);
        end
        issue(OP_SLT, 4'd13, 4'd10, 4'd10, '0, '0);   // Same register twice
    endtask

    task automatic zero_register();
        issue(OP_ADD, 4'd0, 4'd3, 4'd4, '0, '0);
        issue(OP_LUI, 4'd0, 4'd0, 4'd0, 32'hDEAD_BEEF, '0);
        issue(OP_ADD, 4'd5, 4'd0, 4'd7, '0, '0);   // Copy of x7
        issue(OP_SUB, 4'd6, 4'd0, 4'd0, '0, '0);
    endtask

    task automatic csr_access();
        issue(OP_CSRRW, 4'd8, 4'd2, 4'd0, '0, CSR_MSCRATCH);   // Zero since reset
        issue(OP_CSRRW, 4'd9, 4'd3, 4'd0, '0, CSR_MSCRATCH);
        issue(OP_CSRRW, 4'd13, 4'd4, 4'd0, '0, CSR_INSTRET);
        issue(OP_CSRRW, 4'd14, 4'd5, 4'd0, '0, CSR_INSTRET);   // Previous write had no effect
        issue(OP_CSRRW, 4'd1, 4'd6, 4'd0, '0, 12'h7C0);
        issue(OP_CSRRW, 4'd15, 4'd0, 4'd0, '0, CSR_MSCRATCH);
    endtask

    task automatic gaps_and_nops();
        int k;
        for (k = 0; k < 8; k++) begin
            idle_for({$random(seed)} % 6);
            issue((k % 2) ? OP_ADD : OP_XOR, rand_reg(), rand_reg(), rand_reg(), '0, '0);
            idle_for({$random(seed)} % 4);
            issue(OP_NOP, rand_reg(), rand_reg(), rand_reg(), '0, '0);
        end
        issue(OP_CSRRW, 4'd7, 4'd0, 4'd0, '0, CSR_INSTRET);   // NOPs left out of the count
    endtask

    initial begin
        seed = 1;
        errors = 0;
        ref_mscratch = '0;
        ref_instret = '0;
        foreach (ref_regs[r])
            ref_regs[r] = '0;
        rstn = 1'b0;
        instr_valid = 1'b0;
        op = OP_NOP;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        csr_addr = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        idle_for(6);
        load_registers();
        alu_ops();
        signed_compare();
        zero_register();
        csr_access();
        gaps_and_nops();
        idle_for(3);
        $display("Errors: %0d check, %0d assertion", errors, UUT.u_props.assertion_failures);
        if (errors == 0 && UUT.u_props.assertion_failures == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== nibble_core.f ====
hdl/nibble_core_pkg.sv
hdl/nibble_sequencer.sv
hdl/nibble_alu.sv
hdl/nibble_regfile.sv
hdl/nibble_csr.sv
hdl/nibble_core.sv
bench/nibble_core_properties.sv
bench/nibble_core_tb.sv

// ==== Bender.yml ====
package:
  name: nibble_core

sources:
  - hdl/nibble_core_pkg.sv
  - hdl/nibble_sequencer.sv
  - hdl/nibble_alu.sv
  - hdl/nibble_regfile.sv
  - hdl/nibble_csr.sv
  - hdl/nibble_core.sv
  - target: test
    files:
      - bench/nibble_core_properties.sv
      - bench/nibble_core_tb.sv
